/* Bender.yml */
package:
  name: skdecode

sources:
  - hw/skdecode_pkg.sv
  - hw/skdecode_s1s2_unpack.sv
  - hw/skdecode_s1s2_ctrl.sv
  - hw/skdecode_regs.sv
  - hw/skdecode_top.sv
  - target: test
    files:
      - tb/tb_skdecode.sv

/* build.f */
hw/skdecode_pkg.sv
hw/skdecode_s1s2_unpack.sv
hw/skdecode_s1s2_ctrl.sv
hw/skdecode_regs.sv
hw/skdecode_top.sv
tb/tb_skdecode.sv

/* hw/skdecode_pkg.sv */
/* shared ML-DSA constants, eta field and coefficient widths,
   memory geometry and register map of the s1/s2 key decoder */

`default_nettype none

package skdecode_pkg;

    // ML-DSA prime modulus, all coefficients are reduced into [0, q)
    localparam int MLDSA_Q = 8380417;

    // eta bound of the parameter set handled here
    localparam int MLDSA_ETA = 2;

    // one packed field carries a value in 0..2*eta, so 3 bits are needed
    localparam int ETA_SIZE = 3;

    // width of a single stored coefficient
    localparam int REG_SIZE = 24;

    // a key word holds this many packed fields
    localparam int COEFF_PER_WORD = 8;
    localparam int WORD_W         = ETA_SIZE * COEFF_PER_WORD;

    // one memory write carries a whole key word worth of coefficients
    localparam int MEM_DATA_W = REG_SIZE * COEFF_PER_WORD;

    // 256 coefficients per polynomial, eight per memory word
    localparam int WORDS_PER_POLY = 256 / COEFF_PER_WORD;

    // polynomial count register, a value of 0 runs a single polynomial
    localparam int NPOLY_W = 4;

    // word address into the polynomial memory, also the word index of a run
    localparam int MEM_ADDR_W = 9;

    // software register port
    localparam int REG_ADDR_W = 2;
    localparam int REG_DATA_W = 32;

    // register map
    localparam logic [REG_ADDR_W-1:0] REG_CTRL    = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_NPOLY   = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS  = 2'd2;
    localparam logic [REG_ADDR_W-1:0] REG_ERR_IDX = 2'd3;

endpackage

`default_nettype wire

/* hw/skdecode_regs.sv */
/* software register block of the key decoder, control strobes,
   polynomial count, sticky status and latched error index */

`timescale 1ns/1ps
`default_nettype none

module skdecode_regs (
    input  wire logic                                  clk,
    input  wire logic                                  rst_i,
    input  wire logic                                  reg_we_i,
    input  wire logic [skdecode_pkg::REG_ADDR_W-1:0]   reg_addr_i,
    input  wire logic [skdecode_pkg::REG_DATA_W-1:0]   reg_wdata_i,
    output logic      [skdecode_pkg::REG_DATA_W-1:0]   reg_rdata_o,
    output logic                                       start_o,
    output logic      [skdecode_pkg::NPOLY_W-1:0]      npoly_o,
    input  wire logic                                  busy_i,
    input  wire logic                                  done_i,
    input  wire logic                                  err_i,
    input  wire logic [skdecode_pkg::MEM_ADDR_W-1:0]   err_idx_i
);

    logic                                  ctrl_wr;
    logic                                  npoly_wr;
    logic                                  start_q;
    logic                                  done_q;
    logic                                  err_q;
    logic [skdecode_pkg::NPOLY_W-1:0]      npoly_q;
    logic [skdecode_pkg::MEM_ADDR_W-1:0]   err_idx_q;

    assign ctrl_wr  = reg_we_i && (reg_addr_i == skdecode_pkg::REG_CTRL);
    assign npoly_wr = reg_we_i && (reg_addr_i == skdecode_pkg::REG_NPOLY);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            start_q   <= 1'b0;
            npoly_q   <= skdecode_pkg::NPOLY_W'(1);
            done_q    <= 1'b0;
            err_q     <= 1'b0;
            err_idx_q <= '0;
        end
        else begin
            // CTRL bit 0 fires a single start pulse and is not stored
            // whether the controller takes it is decided over there
            start_q <= ctrl_wr && reg_wdata_i[0];

            if (npoly_wr) begin
                npoly_q <= reg_wdata_i[skdecode_pkg::NPOLY_W-1:0];
            end

            // sticky done, a new pulse wins over a clear in the same cycle
            if (done_i) begin
                done_q <= 1'b1;
            end
            else if (ctrl_wr && reg_wdata_i[1]) begin
                done_q <= 1'b0;
            end

            // sticky error, same priority as done
            if (err_i) begin
                err_q <= 1'b1;
            end
            else if (ctrl_wr && reg_wdata_i[1]) begin
                err_q <= 1'b0;
            end

            // keeps the most recent failing word until the next error
            if (err_i) begin
                err_idx_q <= err_idx_i;
            end
        end
    end

    assign start_o = start_q;
    assign npoly_o = npoly_q;

    // read path, CTRL holds only write strobes so it reads back as zero
    always_comb begin
        case (reg_addr_i)
            skdecode_pkg::REG_CTRL:    reg_rdata_o = '0;
            skdecode_pkg::REG_NPOLY:   reg_rdata_o = skdecode_pkg::REG_DATA_W'(npoly_q);
            // status layout is {error, done, busy}
            skdecode_pkg::REG_STATUS:  reg_rdata_o =
                skdecode_pkg::REG_DATA_W'({err_q, done_q, busy_i});
            skdecode_pkg::REG_ERR_IDX: reg_rdata_o = skdecode_pkg::REG_DATA_W'(err_idx_q);
            default:                   reg_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/skdecode_s1s2_ctrl.sv */
/* s1/s2 decode run controller, eight unpack lanes, word counter
   and the registered memory write stage with error abort */

`timescale 1ns/1ps
`default_nettype none

module skdecode_s1s2_ctrl (
    input  wire logic                                    clk,
    input  wire logic                                    rst_i,
    input  wire logic                                    start_i,
    input  wire logic [skdecode_pkg::NPOLY_W-1:0]        npoly_i,
    input  wire logic [skdecode_pkg::WORD_W-1:0]         word_i,
    input  wire logic                                    word_valid_i,
    output logic                                         mem_we_o,
    output logic      [skdecode_pkg::MEM_ADDR_W-1:0]     mem_addr_o,
    output logic      [skdecode_pkg::MEM_DATA_W-1:0]     mem_wdata_o,
    output logic                                         busy_o,
    output logic                                         done_o,
    output logic                                         err_o,
    output logic      [skdecode_pkg::MEM_ADDR_W-1:0]     err_idx_o
);

    logic                                      busy_q;
    logic [skdecode_pkg::MEM_ADDR_W-1:0]       word_cnt_q;
    logic [skdecode_pkg::MEM_ADDR_W-1:0]       last_idx;
    logic [skdecode_pkg::NPOLY_W-1:0]          npoly_eff;
    logic                                      lane_en;
    logic [skdecode_pkg::COEFF_PER_WORD-1:0]   lane_valid;
    logic [skdecode_pkg::COEFF_PER_WORD-1:0]   lane_err;
    logic [skdecode_pkg::MEM_DATA_W-1:0]       lane_data;
    logic                                      word_take;
    logic                                      word_bad;

    // a count of zero would mean an empty run, treat it as one polynomial
    assign npoly_eff = (npoly_i == '0) ? skdecode_pkg::NPOLY_W'(1) : npoly_i;

    // index of the final word of the run, at most 15*32-1 so it fits the address
    assign last_idx = skdecode_pkg::MEM_ADDR_W'(npoly_eff)
                    * skdecode_pkg::MEM_ADDR_W'(skdecode_pkg::WORDS_PER_POLY)
                    - skdecode_pkg::MEM_ADDR_W'(1);

    // words only count during a run, strobes while idle are dropped here
    assign lane_en = busy_q & word_valid_i;

    // lane j reads field j of the word and fills coefficient slot j
    for (genvar j = 0; j < skdecode_pkg::COEFF_PER_WORD; j++) begin : g_lane
        skdecode_s1s2_unpack u_unpack (
            .data_i   (word_i[j*skdecode_pkg::ETA_SIZE +: skdecode_pkg::ETA_SIZE]),
            .enable_i (lane_en),
            .data_o   (lane_data[j*skdecode_pkg::REG_SIZE +: skdecode_pkg::REG_SIZE]),
            .valid_o  (lane_valid[j]),
            .error_o  (lane_err[j])
        );
    end

    // all lanes share one enable, so their valids agree
    assign word_take = &lane_valid;

    // a single bad field poisons the whole word
    assign word_bad = |lane_err;

    // run state, write strobe and the done and error pulses
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            word_cnt_q <= '0;
            mem_we_o   <= 1'b0;
            done_o     <= 1'b0;
            err_o      <= 1'b0;
        end
        else begin
            // strobes and pulses last one cycle unless set again below
            mem_we_o <= 1'b0;
            done_o   <= 1'b0;
            err_o    <= 1'b0;

            if (!busy_q) begin
                // a start seen while busy falls through to the branch below unused
                if (start_i) begin
                    busy_q     <= 1'b1;
                    word_cnt_q <= '0;
                end
            end
            else if (word_take) begin
                if (word_bad) begin
                    // abort, the bad word and anything after it are never written
                    busy_q <= 1'b0;
                    err_o  <= 1'b1;
                end
                else begin
                    mem_we_o   <= 1'b1;
                    word_cnt_q <= word_cnt_q + 1'b1;

                    // the last word ends the run at the same edge it is taken
                    if (word_cnt_q == last_idx) begin
                        busy_q <= 1'b0;
                        done_o <= 1'b1;
                    end
                end
            end
        end
    end

    // write payload follows the accepted word, qualified by mem_we_o
    always_ff @(posedge clk) begin
        if (word_take) begin
            mem_addr_o  <= word_cnt_q;
            mem_wdata_o <= lane_data;
        end

        // index of the failing word lines up with the err_o pulse
        if (word_take && word_bad) begin
            err_idx_o <= word_cnt_q;
        end
    end

    assign busy_o = busy_q;

endmodule

`default_nettype wire

/* hw/skdecode_s1s2_unpack.sv */
/* combinational unpack of one eta-packed field into a coefficient mod q,
   flags fields outside the 0..2*eta range */

`timescale 1ns/1ps
`default_nettype none

module skdecode_s1s2_unpack (
    input  wire logic [skdecode_pkg::ETA_SIZE-1:0] data_i,
    input  wire logic                              enable_i,
    output logic      [skdecode_pkg::REG_SIZE-1:0] data_o,
    output logic                                   valid_o,
    output logic                                   error_o
);

    // eta minus the field, allowed to wrap in REG_SIZE bits
    logic [skdecode_pkg::REG_SIZE-1:0] eta_minus_data;

    assign eta_minus_data = skdecode_pkg::REG_SIZE'(skdecode_pkg::MLDSA_ETA)
                          - skdecode_pkg::REG_SIZE'(data_i);

    // coefficient is eta - v, a legal field lies in 0..2*eta
    // fields up to eta give a small non-negative result directly
    // fields above eta are negative and get q added, the wrap in
    // eta_minus_data cancels against the truncation of q + (eta - v)
    always_comb begin
        data_o  = '0;
        valid_o = 1'b0;
        error_o = 1'b0;

        if (enable_i) begin
            valid_o = 1'b1;

            if (data_i <= skdecode_pkg::MLDSA_ETA) begin
                // 0, 1, 2 map to 2, 1, 0
                data_o = eta_minus_data;
            end
            else if (data_i <= 2 * skdecode_pkg::MLDSA_ETA) begin
                // 3 and 4 map to q-1 and q-2
                data_o = skdecode_pkg::REG_SIZE'(skdecode_pkg::MLDSA_Q) + eta_minus_data;
            end
            else begin
                // 5, 6 and 7 cannot come from a valid key
                // the coefficient stays zero so nothing meaningful leaks out
                error_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/skdecode_top.sv */
/* top level of the s1/s2 key decoder, register block
   beside the run controller it steers */

`timescale 1ns/1ps
`default_nettype none

module skdecode_top (
    input  wire logic                                  clk,
    input  wire logic                                  rst_i,
    input  wire logic                                  reg_we_i,
    input  wire logic [skdecode_pkg::REG_ADDR_W-1:0]   reg_addr_i,
    input  wire logic [skdecode_pkg::REG_DATA_W-1:0]   reg_wdata_i,
    output logic      [skdecode_pkg::REG_DATA_W-1:0]   reg_rdata_o,
    input  wire logic [skdecode_pkg::WORD_W-1:0]       word_i,
    input  wire logic                                  word_valid_i,
    output logic                                       mem_we_o,
    output logic      [skdecode_pkg::MEM_ADDR_W-1:0]   mem_addr_o,
    output logic      [skdecode_pkg::MEM_DATA_W-1:0]   mem_wdata_o
);

    // software side to controller
    logic                                  start_pulse;
    logic [skdecode_pkg::NPOLY_W-1:0]      npoly;

    // controller back to the status registers
    logic                                  busy;
    logic                                  done_pulse;
    logic                                  err_pulse;
    logic [skdecode_pkg::MEM_ADDR_W-1:0]   err_idx;

    skdecode_regs u_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .start_o     (start_pulse),
        .npoly_o     (npoly),
        .busy_i      (busy),
        .done_i      (done_pulse),
        .err_i       (err_pulse),
        .err_idx_i   (err_idx)
    );

    skdecode_s1s2_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .start_i      (start_pulse),
        .npoly_i      (npoly),
        .word_i       (word_i),
        .word_valid_i (word_valid_i),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .busy_o       (busy),
        .done_o       (done_pulse),
        .err_o        (err_pulse),
        .err_idx_o    (err_idx)
    );

endmodule

`default_nettype wire

/* tb/tb_skdecode.sv */
/* self-checking testbench of the s1/s2 key decoder, memory write monitor
   with an expected-word queue, LCG stimulus and five directed runs */

`timescale 1ns/1ps
`default_nettype none

module tb_skdecode;

    logic                                  clk;
    logic                                  rst_i;
    logic                                  reg_we_i;
    logic [skdecode_pkg::REG_ADDR_W-1:0]   reg_addr_i;
    logic [skdecode_pkg::REG_DATA_W-1:0]   reg_wdata_i;
    logic [skdecode_pkg::REG_DATA_W-1:0]   reg_rdata_o;
    logic [skdecode_pkg::WORD_W-1:0]       word_i;
    logic                                  word_valid_i;
    logic                                  mem_we_o;
    logic [skdecode_pkg::MEM_ADDR_W-1:0]   mem_addr_o;
    logic [skdecode_pkg::MEM_DATA_W-1:0]   mem_wdata_o;

    // expected writes in issue order and every write seen by address
    logic [skdecode_pkg::MEM_ADDR_W-1:0]   exp_addr_q[$];
    logic [skdecode_pkg::MEM_DATA_W-1:0]   exp_data_q[$];
    logic [skdecode_pkg::MEM_DATA_W-1:0]   mem_model[int];
    logic [skdecode_pkg::MEM_ADDR_W-1:0]   next_addr;
    int          errors;
    int          checks;
    int          tests_run;
    int          err_base;
    int          write_count;
    int          streak;
    int          max_streak;
    int unsigned lcg_state;
    string       test_name;

    skdecode_top u_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .word_i       (word_i),
        .word_valid_i (word_valid_i),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

    always #50 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // each lane holds 2 - v taken modulo q where v is field j of the word
    function automatic logic [191:0] expected_lanes(input logic [23:0] word);
        logic [191:0] lanes;
        int           v;
        int           j;
        for (j = 0; j < 8; j++) begin
            v = int'(word[3*j +: 3]);
            lanes[24*j +: 24] = 24'((2 - v + skdecode_pkg::MLDSA_Q) % skdecode_pkg::MLDSA_Q);
        end
        return lanes;
    endfunction

    // every field drawn from the legal range 0..4
    function automatic logic [23:0] random_word();
        logic [23:0] rw;
        int          j;
        for (j = 0; j < 8; j++) begin
            rw[3*j +: 3] = 3'(lcg_next() % 5);
        end
        return rw;
    endfunction

    task automatic check_val(input string what, input logic [191:0] exp,
                             input logic [191:0] act);
        checks++;
        assert (exp === act) else begin
            $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // all bus tasks start and end 5 ns after a rising edge
    task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge clk);
        #5;
        reg_we_i = 1'b0;
    endtask

    // read data is combinational and is taken in the middle of the cycle
    task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
        reg_addr_i = addr;
        @(negedge clk);
        data = reg_rdata_o;
        @(posedge clk);
        #5;
    endtask

    task automatic send_word(input logic [23:0] word, input logic expect_write);
        if (expect_write) begin
            exp_addr_q.push_back(next_addr);
            exp_data_q.push_back(expected_lanes(word));
            next_addr++;
        end
        word_i       = word;
        word_valid_i = 1'b1;
        @(posedge clk);
        #5;
        word_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    // busy should rise two cycles after the CTRL write
    task automatic start_run(input int npoly);
        logic [31:0] st;
        int          n;
        reg_write(skdecode_pkg::REG_NPOLY, npoly);
        reg_write(skdecode_pkg::REG_CTRL, 32'd1);
        st = '0;
        n  = 0;
        while (!st[0] && n < 20) begin
            reg_read(skdecode_pkg::REG_STATUS, st);
            n++;
        end
        if (!st[0]) begin
            $display("timeout, the run in test %s never became busy", test_name);
            errors++;
        end
    endtask

    // the run is over once busy is low and no expected write is pending
    task automatic wait_idle();
        logic [31:0] st;
        int          n;
        n = 0;
        reg_read(skdecode_pkg::REG_STATUS, st);
        while ((st[0] || exp_addr_q.size() != 0) && n < 400) begin
            reg_read(skdecode_pkg::REG_STATUS, st);
            n++;
        end
        if (st[0] || exp_addr_q.size() != 0) begin
            $display("timeout, the run in test %s did not finish", test_name);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        err_base    = errors;
        write_count = 0;
        max_streak  = 0;
        next_addr   = '0;
        mem_model.delete();
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-8s %s", test_name, (errors == err_base) ? "ok" : "had errors");
    endtask

    // mem_we_o is registered and therefore stable at the falling edge where writes are logged
    always @(negedge clk) begin
        if (mem_we_o === 1'b1) begin
            write_count++;
            streak++;
            mem_model[int'(mem_addr_o)] = mem_wdata_o;
            assert (exp_addr_q.size() != 0) else begin
                $display("unexpected memory write to address %0d in test %s",
                         mem_addr_o, test_name);
                errors++;
            end
            if (exp_addr_q.size() != 0) begin
                check_val("address", exp_addr_q.pop_front(), mem_addr_o);
                check_val("data", exp_data_q.pop_front(), mem_wdata_o);
            end
        end
        else begin
            streak = 0;
        end
        if (streak > max_streak) begin
            max_streak = streak;
        end
    end

    // hard limit on the whole run
    initial begin
        #1000000;
        $display("simulation limit reached before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [23:0] w;
        int          k;
        clk          = 1'b0;
        rst_i        = 1'b1;
        reg_we_i     = 1'b0;
        reg_addr_i   = '0;
        reg_wdata_i  = '0;
        word_i       = '0;
        word_valid_i = 1'b0;
        lcg_state    = 47;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        streak       = 0;
        repeat (16) @(posedge clk);
        #5;
        rst_i = 1'b0;

        begin_test("reset");
        reg_read(skdecode_pkg::REG_STATUS, rd);
        check_val("status", 0, rd);
        reg_read(skdecode_pkg::REG_NPOLY, rd);
        check_val("npoly", 1, rd);
        idle(4);
        check_val("writes", 0, write_count);
        end_test();

        // word 0 carries every legal field value and the rest are random
        begin_test("mapping");
        start_run(1);
        for (k = 0; k < 32; k++) begin
            w = random_word();
            if (k == 0) begin
                w = {3'd2, 3'd1, 3'd0, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0};
            end
            send_word(w, 1'b1);
        end
        wait_idle();
        check_val("writes", 32, write_count);
        check_val("burst", 32, max_streak);
        reg_write(skdecode_pkg::REG_CTRL, 32'd2);
        end_test();

        // three polynomials with random gaps of 0 to 2 cycles
        begin_test("length");
        start_run(3);
        for (k = 0; k < 96; k++) begin
            send_word(random_word(), 1'b1);
            idle(lcg_next() % 3);
        end
        wait_idle();
        check_val("writes", 96, write_count);
        check_val("addresses", 96, mem_model.size());
        reg_read(skdecode_pkg::REG_STATUS, rd);
        check_val("status", 2, rd);
        reg_write(skdecode_pkg::REG_CTRL, 32'd2);
        reg_read(skdecode_pkg::REG_STATUS, rd);
        check_val("cleared", 0, rd);
        end_test();

        // word 5 has a 6 in lane 3 so neither it nor any later word may be written
        begin_test("invalid");
        start_run(1);
        for (k = 0; k < 5; k++) begin
            send_word(random_word(), 1'b1);
        end
        w = random_word();
        w[9 +: 3] = 3'd6;
        send_word(w, 1'b0);
        for (k = 0; k < 3; k++) begin
            send_word(random_word(), 1'b0);
        end
        wait_idle();
        check_val("writes", 5, write_count);
        reg_read(skdecode_pkg::REG_STATUS, rd);
        check_val("status", 4, rd);
        reg_read(skdecode_pkg::REG_ERR_IDX, rd);
        check_val("err_idx", 5, rd);
        reg_write(skdecode_pkg::REG_CTRL, 32'd2);
        end_test();

        // strobes while idle are dropped and a start during the run is ignored
        begin_test("idle");
        for (k = 0; k < 4; k++) begin
            send_word(random_word(), 1'b0);
            idle(1);
        end
        check_val("idle writes", 0, write_count);
        start_run(1);
        for (k = 0; k < 32; k++) begin
            if (k == 10) begin
                reg_write(skdecode_pkg::REG_CTRL, 32'd1);
            end
            send_word(random_word(), 1'b1);
        end
        wait_idle();
        check_val("writes", 32, write_count);
        reg_read(skdecode_pkg::REG_STATUS, rd);
        check_val("status", 2, rd);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
